// ==== bench/memPipeTb.sv ====
`timescale 1ns/1ns
`default_nettype none

// Testbench for the load/store slice, reference byte model plus compare process
module memPipeTb import memPkg::*; ();

	typedef struct packed {
		logic [31:0] due;    // Cycle the response shows up
		logic        store;
		logic        fault;
		regIdx       rd;
		dataWord     data;
	} respEntry;

	logic     clk, rstN, opValid, opStore, debugWe;
	widthCode opWidth;
	dataWord  opBase, opOffset, opStoreData, debugData;
	regIdx    opRd;
	byteAddr  debugAddr;
	logic     respValid, respStore, respFault;
	regIdx    respRd;
	dataWord  respData;

	logic [7:0]  shadow [0:4095];  // Byte image, 4 KiB wraps
	respEntry    expQ [$];         // Expected responses in issue order
	logic [31:0] cycle = '0;       // Rising edges seen
	logic        checkOn = 1'b0;
	string       testName = "reset";

	memPipeTop i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 32'd1;

	//////////////////////////////////////////////////
	// Failure reporting
	//////////////////////////////////////////////////
	task automatic stopOnFailure(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic reportMismatch(input string field, input logic [31:0] expV,
			input logic [31:0] actV);
		stopOnFailure($sformatf("mismatch test=%s field=%s expected=%h actual=%h",
			testName, field, expV, actV));
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////
	function automatic dataWord fillWord(input byteAddr wa);
		return {6'h2A, wa[11:2], 6'h15, wa[11:2]};  // Every index bit shows
	endfunction

	function automatic respEntry refResponse(input logic store, input widthCode w,
			input byteAddr a, input regIdx rd);
		respEntry    e;
		logic [11:0] b;
		b       = a[11:0];  // Wrap at memory size
		e.due   = '0;
		e.store = store;
		e.rd    = rd;
		e.data  = '0;
		case (w)
			opByte, opByteU: e.fault = 1'b0;
			opHalf, opHalfU: e.fault = a[0];
			default:         e.fault = a[1] | a[0];
		endcase
		if (!store && !e.fault) begin  // Little endian gather
			case (w)
				opByte:  e.data = {{24{shadow[b][7]}}, shadow[b]};
				opByteU: e.data = {24'h0, shadow[b]};
				opHalf:  e.data = {{16{shadow[b + 12'd1][7]}}, shadow[b + 12'd1], shadow[b]};
				opHalfU: e.data = {16'h0, shadow[b + 12'd1], shadow[b]};
				default: e.data = {shadow[b + 12'd3], shadow[b + 12'd2],
					shadow[b + 12'd1], shadow[b]};
			endcase
		end
		return e;
	endfunction

	task automatic writeShadow(input widthCode w, input byteAddr a, input dataWord d);
		int n;
		n = (w == opByte) ? 1 : (w == opHalf) ? 2 : 4;
		for (int k = 0; k < n; k++) begin
			shadow[a[11:0] + 12'(k)] = d[8*k +: 8];
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	task automatic issueOp(input logic store, input widthCode w, input dataWord base,
			input dataWord off, input dataWord sdata, input regIdx rd);
		respEntry e;
		byteAddr  a;
		@(posedge clk);
		#1;
		a           = base + off;
		opValid     = 1'b1;
		opStore     = store;
		opWidth     = w;
		opBase      = base;
		opOffset    = off;
		opStoreData = sdata;
		opRd        = rd;
		e           = refResponse(store, w, a, rd);  // Sees every older store
		e.due       = cycle + 32'd3;
		expQ.push_back(e);
		if (store && !e.fault) writeShadow(w, a, sdata);
	endtask

	task automatic storeOp(input widthCode w, input byteAddr a, input dataWord d);
		issueOp(1'b1, w, a + 32'd8, 32'hFFFF_FFF8, d, 5'd0);  // Negative offset
	endtask

	task automatic loadOp(input widthCode w, input byteAddr a, input regIdx rd);
		issueOp(1'b0, w, a - 32'd20, 32'd20, 32'h0, rd);
	endtask

	task automatic debugWrite(input byteAddr a, input dataWord d);
		@(posedge clk);
		#1;
		debugWe   = 1'b1;
		debugAddr = a;
		debugData = d;
		writeShadow(opWord, {20'h0, a[11:2], 2'b00}, d);  // Upper bits dropped
	endtask

	// Idle the bus and wait for every response
	task automatic drainQueue();
		int waited;
		waited = 0;
		@(posedge clk);
		#1;
		opValid = 1'b0;
		debugWe = 1'b0;
		while (expQ.size() != 0 && waited < 20) begin
			@(posedge clk);
			waited++;
		end
		if (expQ.size() != 0)
			stopOnFailure($sformatf("timeout with responses still pending in test %s", testName));
	endtask

	//////////////////////////////////////////////////
	// Compare process, sampled mid-cycle
	//////////////////////////////////////////////////
	always @(negedge clk) begin : compareResp
		respEntry head;
		if (checkOn) begin
			if (respValid === 1'b1) begin
				assert (expQ.size() != 0)
					else stopOnFailure($sformatf("unexpected response in test %s", testName));
				head = expQ.pop_front();
				assert (head.due == cycle) else reportMismatch("cycle", head.due, cycle);
				assert (respStore === head.store)
					else reportMismatch("respStore", {31'd0, head.store}, {31'd0, respStore});
				assert (respFault === head.fault)
					else reportMismatch("respFault", {31'd0, head.fault}, {31'd0, respFault});
				assert (respRd === head.rd)
					else reportMismatch("respRd", {27'd0, head.rd}, {27'd0, respRd});
				assert (respData === head.data) else reportMismatch("respData", head.data, respData);
			end else begin
				assert (respValid === 1'b0) else stopOnFailure("respValid is neither high nor low");
				assert (expQ.size() == 0 || expQ[0].due != cycle)
					else stopOnFailure($sformatf("response missing in test %s", testName));
			end
		end
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial begin
		logic [31:0] r, s, d;
		dataWord     base, off;
		byteAddr     a;
		widthCode    w;
		rstN        = 1'b0;
		opValid     = 1'b0;
		opStore     = 1'b0;
		opWidth     = opWord;
		opBase      = '0;
		opOffset    = '0;
		opStoreData = '0;
		opRd        = '0;
		debugWe     = 1'b0;
		debugAddr   = '0;
		debugData   = '0;
		void'($urandom(78582));
		repeat (3) @(posedge clk);
		#1;
		rstN    = 1'b1;
		checkOn = 1'b1;

		testName = "reset idle";
		for (int k = 0; k < 5; k++) begin
			@(negedge clk);
			assert (respValid === 1'b0) else stopOnFailure("respValid high after reset with no op");
		end

		testName = "debug fill";  // Known image in every word
		for (int k = 0; k < memWords; k++) begin
			debugWrite(32'(k) << 2, fillWord(32'(k) << 2));
		end
		drainQueue();

		testName = "word store load";
		for (int k = 0; k < 6; k++) begin
			a = 32'(k) * 32'h2A4;  // Spread, word aligned
			storeOp(opWord, a, 32'hC0DE_0000 | 32'(k));
			loadOp(opWord, a, 5'(k + 1));  // Right behind the store
		end
		drainQueue();

		testName = "sub-word lanes";
		for (int k = 0; k < 4; k++) begin
			a = 32'h100 + 32'(k);
			storeOp(opByte, a, 32'hFFFF_FF00 | (32'(k) * 32'h41));  // Both signs
			loadOp(opByte, a, 5'd3);
			loadOp(opByteU, a, 5'd4);
			loadOp(opWord, 32'h100, 5'd5);  // Neighbour lanes intact
		end
		for (int k = 0; k < 4; k += 2) begin
			a = 32'h180 + 32'(k);
			storeOp(opHalf, a, 32'hABCD_0000 | (32'(k) * 32'h3FFF + 32'h7F01));
			loadOp(opHalf, a, 5'd6);
			loadOp(opHalfU, a, 5'd7);
			loadOp(opWord, 32'h180, 5'd8);
		end
		drainQueue();

		testName = "misaligned";
		storeOp(opWord, 32'h200, 32'h1122_3344);
		storeOp(opHalf, 32'h201, 32'h0000_DEAD);
		storeOp(opWord, 32'h202, 32'hBEEF_0000);
		storeOp(opWord, 32'h203, 32'h5555_AAAA);
		loadOp(opHalf, 32'h203, 5'd9);
		loadOp(opHalfU, 32'h201, 5'd10);
		loadOp(opWord, 32'h201, 5'd11);
		loadOp(opWord, 32'h200, 5'd12);  // Still the first store
		drainQueue();

		testName = "debug image and wrap";
		for (int k = 0; k < 8; k++) begin
			debugWrite(32'h300 + 32'(4 * k), 32'h600D_F00D ^ (32'(k) * 32'h0101_0101));
		end
		debugWrite(32'h0000_1040, 32'hCAFE_BABE);  // Lands on 0x040
		drainQueue();
		for (int k = 0; k < 8; k++) begin
			loadOp(opWord, 32'h300 + 32'(4 * k), 5'(k));
		end
		loadOp(opWord, 32'h0000_0040, 5'd13);
		loadOp(opWord, 32'h7FFF_3040, 5'd14);
		storeOp(opWord, 32'hFFFF_FFFC, 32'h0BAD_C0DE);  // Top word of memory
		loadOp(opWord, 32'h0000_0FFC, 5'd15);
		drainQueue();

		testName = "random stream";
		for (int k = 0; k < 400; k++) begin
			r    = $urandom();
			s    = $urandom();
			d    = $urandom();
			base = {s[31:28], 16'h0, 4'h3, r[15:8]};  // Hot window, random upper bits
			off  = {{24{s[7]}}, s[7:0]};
			if (r[3])
				w = (r[1:0] == 2'd0) ? opByte : (r[1:0] == 2'd1) ? opHalf : opWord;
			else
				w = (r[2:0] == 3'd3) ? opByteU : (r[2:0] >= 3'd4) ? opHalfU : widthCode'(r[2:0]);
			a = base + off;
			if (r[17:16] != 2'b00) begin  // Mostly aligned
				case (w)
					opHalf, opHalfU: off = off - {31'd0, a[0]};
					opWord:          off = off - {30'd0, a[1:0]};
					default:         ;
				endcase
			end
			issueOp(r[3], w, base, off, d, r[24:20]);
		end
		drainQueue();

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/memPipe_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

// Response timing and debug port checks
module memPipeAssert (
	input wire logic clk,
	input wire logic rstN,
	input wire logic opValid,
	input wire logic s1Valid,
	input wire logic s2Valid,
	input wire logic respValid,
	input wire logic debugWe
);

	//////////////////////////////////////////////////
	// Fixed latency of 3 edges
	//////////////////////////////////////////////////
	latencyForward: assert property (@(posedge clk) disable iff (!rstN)
		$past(opValid, 3) |-> respValid)
		else $error("respValid missing three edges after opValid");

	latencyBackward: assert property (@(posedge clk) disable iff (!rstN)
		respValid |-> $past(opValid, 3))  // No response out of thin air
		else $error("respValid without an operation three edges earlier");

	// First cycle out of reset is quiet
	resetQuiet: assert property (@(posedge clk) $rose(rstN) |-> !respValid)
		else $error("respValid high in the cycle after reset");

	//////////////////////////////////////////////////
	// Debug port only while the pipe is empty
	//////////////////////////////////////////////////
	debugIdle: assert property (@(posedge clk) disable iff (!rstN)
		debugWe |-> !(opValid || s1Valid || s2Valid))
		else $error("debug write while an operation is in flight");

endmodule

bind memPipeTop memPipeAssert i_memPipeAssert (
	.clk       (clk),
	.rstN      (rstN),
	.opValid   (opValid),
	.s1Valid   (s1Valid),   // Top-level internal wires
	.s2Valid   (s2Valid),
	.respValid (respValid),
	.debugWe   (debugWe)
);

`default_nettype wire

// ==== files.f ====
hdl/memPkg.sv
hdl/addrStage.sv
hdl/dataMemory.sv
hdl/memoryStage.sv
hdl/loadAlign.sv
hdl/memPipeTop.sv
bench/memPipe_assert.sv
bench/memPipeTb.sv

// ==== hdl/addrStage.sv ====
`timescale 1ns/1ns
`default_nettype none

// EX/MEM boundary, effective address and alignment
module addrStage import memPkg::*; (
	input  wire logic     clk,
	input  wire logic     rstN,
	input  wire logic     opValid,
	input  wire logic     opStore,
	input  wire widthCode opWidth,
	input  wire dataWord  opBase,
	input  wire dataWord  opOffset,
	input  wire dataWord  opStoreData,
	input  wire regIdx    opRd,
	output logic          s1Valid,
	output logic          s1Store,
	output widthCode      s1Width,
	output byteAddr       s1Addr,
	output dataWord       s1StoreData,
	output regIdx         s1Rd,
	output logic          s1Misaligned
);

	byteAddr effAddr;     // base + offset
	logic    misaligned;  // From width and low bits

	//////////////////////////////////////////////////
	// Address adder
	//////////////////////////////////////////////////
	assign effAddr = opBase + opOffset;  // Carry out dropped

	//////////////////////////////////////////////////
	// Alignment check
	//////////////////////////////////////////////////
	always_comb begin
		case (opWidth)
			opByte, opByteU:
				misaligned = 1'b0;  // Bytes always fit
			opHalf, opHalfU:
				misaligned = effAddr[0];  // Needs even address
			default:
				misaligned = |effAddr[1:0];  // Word, and the illegal codes
		endcase
	end

	//////////////////////////////////////////////////
	// Stage 1 register
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			s1Valid <= 1'b0;
		end else begin
			s1Valid <= opValid;
		end
	end

	// Payload, meaningful only with s1Valid
	always_ff @(posedge clk) begin
		s1Store      <= opStore;
		s1Width      <= opWidth;
		s1Addr       <= effAddr;
		s1StoreData  <= opStoreData;
		s1Rd         <= opRd;
		s1Misaligned <= misaligned;
	end

endmodule

`default_nettype wire

// ==== hdl/dataMemory.sv ====
`timescale 1ns/1ns
`default_nettype none

// Byte-enabled word memory, registered read
module dataMemory import memPkg::*; (
	input  wire logic                    clk,
	input  wire logic [memIndexBits-1:0] memIndex,
	input  wire logic                    memWe,
	input  wire byteEnable               memBe,
	input  wire dataWord                 memWrData,
	input  wire logic                    memRe,
	input  wire logic                    debugWe,
	input  wire logic [memIndexBits-1:0] debugIndex,
	input  wire dataWord                 debugData,
	output dataWord                      memRdData
);

	dataWord mem [0:memWords-1];  // Word array

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////
	// Pipeline write first, per lane
	// then the debug write, so debug wins on the same word
	always_ff @(posedge clk) begin
		if (memWe) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (memBe[lane]) begin
					mem[memIndex][8*lane +: 8] <= memWrData[8*lane +: 8];
				end
			end
		end
		if (debugWe) begin
			mem[debugIndex] <= debugData;  // Whole word, bootloader style
		end
	end

	//////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////
	// Old contents are read on a same-edge write, but the
	// pipeline never reads and writes in the same cycle.
	// Word holds its value while memRe is low
	always_ff @(posedge clk) begin
		if (memRe) begin
			memRdData <= mem[memIndex];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/loadAlign.sv ====
`timescale 1ns/1ns
`default_nettype none

// WB side, lane select and extension
module loadAlign import memPkg::*; (
	input  wire logic       clk,
	input  wire logic       rstN,
	input  wire logic       s2Valid,
	input  wire logic       s2Store,
	input  wire widthCode   s2Width,
	input  wire logic [1:0] s2Lane,
	input  wire regIdx      s2Rd,
	input  wire logic       s2Fault,
	input  wire dataWord    s2ReadWord,
	output logic            respValid,
	output logic            respStore,
	output logic            respFault,
	output regIdx           respRd,
	output dataWord         respData
);

	dataWord shifted;    // Addressed lane moved to bits 7:0
	dataWord extended;   // After sign or zero extension
	dataWord loadData;   // Zero for stores and faults

	//////////////////////////////////////////////////
	// Lane select and extension
	//////////////////////////////////////////////////
	assign shifted = s2ReadWord >> {s2Lane, 3'b000};

	always_comb begin
		case (s2Width)
			opByte:  extended = {{24{shifted[7]}}, shifted[7:0]};    // LB
			opHalf:  extended = {{16{shifted[15]}}, shifted[15:0]};  // LH
			opByteU: extended = {24'h0, shifted[7:0]};               // LBU
			opHalfU: extended = {16'h0, shifted[15:0]};              // LHU
			default: extended = shifted;  // LW, lane is zero
		endcase
	end

	assign loadData = (s2Store | s2Fault) ? '0 : extended;

	//////////////////////////////////////////////////
	// Response register
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			respValid <= 1'b0;
		end else begin
			respValid <= s2Valid;  // One pulse per op
		end
	end

	always_ff @(posedge clk) begin
		respStore <= s2Store;
		respFault <= s2Fault;
		respRd    <= s2Rd;
		respData  <= loadData;
	end

endmodule

`default_nettype wire

// ==== hdl/memPipeTop.sv ====
`timescale 1ns/1ns
`default_nettype none

// Load/store slice, three stages, fixed latency of 3 edges
module memPipeTop import memPkg::*; (
	input  wire logic     clk,
	input  wire logic     rstN,
	input  wire logic     opValid,
	input  wire logic     opStore,
	input  wire widthCode opWidth,
	input  wire dataWord  opBase,
	input  wire dataWord  opOffset,
	input  wire dataWord  opStoreData,
	input  wire regIdx    opRd,
	input  wire logic     debugWe,     // Bootloader write
	input  wire byteAddr  debugAddr,
	input  wire dataWord  debugData,
	output logic          respValid,
	output logic          respStore,
	output logic          respFault,
	output regIdx         respRd,
	output dataWord       respData
);

	// EX/MEM
	logic       s1Valid, s1Store, s1Misaligned;
	widthCode   s1Width;
	byteAddr    s1Addr;
	dataWord    s1StoreData;
	regIdx      s1Rd;

	// MEM/WB
	logic       s2Valid, s2Store, s2Fault;
	widthCode   s2Width;
	logic [1:0] s2Lane;
	regIdx      s2Rd;
	dataWord    s2ReadWord;

	addrStage i_addrStage (
		.clk(clk), .rstN(rstN),
		.opValid(opValid), .opStore(opStore), .opWidth(opWidth),
		.opBase(opBase), .opOffset(opOffset), .opStoreData(opStoreData), .opRd(opRd),
		.s1Valid(s1Valid), .s1Store(s1Store), .s1Width(s1Width), .s1Addr(s1Addr),
		.s1StoreData(s1StoreData), .s1Rd(s1Rd), .s1Misaligned(s1Misaligned)
	);

	memoryStage i_memoryStage (
		.clk(clk), .rstN(rstN),
		.s1Valid(s1Valid), .s1Store(s1Store), .s1Width(s1Width), .s1Addr(s1Addr),
		.s1StoreData(s1StoreData), .s1Rd(s1Rd), .s1Misaligned(s1Misaligned),
		.debugWe(debugWe), .debugAddr(debugAddr), .debugData(debugData),
		.s2Valid(s2Valid), .s2Store(s2Store), .s2Width(s2Width), .s2Lane(s2Lane),
		.s2Rd(s2Rd), .s2Fault(s2Fault), .s2ReadWord(s2ReadWord)
	);

	loadAlign i_loadAlign (
		.clk(clk), .rstN(rstN),
		.s2Valid(s2Valid), .s2Store(s2Store), .s2Width(s2Width), .s2Lane(s2Lane),
		.s2Rd(s2Rd), .s2Fault(s2Fault), .s2ReadWord(s2ReadWord),
		.respValid(respValid), .respStore(respStore), .respFault(respFault),
		.respRd(respRd), .respData(respData)
	);

endmodule

`default_nettype wire

// ==== hdl/memPkg.sv ====
`default_nettype none

package memPkg;

	//////////////////////////////////////////////////
	// Widths that carry a meaning
	//////////////////////////////////////////////////
	typedef logic [31:0] dataWord;    // Data or register value
	typedef logic [31:0] byteAddr;    // Byte address
	typedef logic [4:0]  regIdx;      // Destination register
	typedef logic [2:0]  widthCode;   // funct3 of load/store
	typedef logic [3:0]  byteEnable;  // One bit per lane

	//////////////////////////////////////////////////
	// Width codes, funct3 encoding
	//////////////////////////////////////////////////
	localparam widthCode opByte  = 3'd0;  // LB / SB
	localparam widthCode opHalf  = 3'd1;  // LH / SH
	localparam widthCode opWord  = 3'd2;  // LW / SW
	localparam widthCode opByteU = 3'd4;  // LBU
	localparam widthCode opHalfU = 3'd5;  // LHU

	// Codes 3, 6 and 7 are not legal, hardware treats them as word

	//////////////////////////////////////////////////
	// Data memory geometry
	//////////////////////////////////////////////////
	localparam int memWords     = 1024;  // Depth in words, 4 KiB
	localparam int memIndexBits = 10;    // log2 of memWords

	// Word index taken from byte address bits 11:2
	// so anything past 4 KiB wraps around

endpackage

`default_nettype wire

// ==== hdl/memoryStage.sv ====
`timescale 1ns/1ns
`default_nettype none

// MEM stage, lane placement and memory access
module memoryStage import memPkg::*; (
	input  wire logic     clk,
	input  wire logic     rstN,
	input  wire logic     s1Valid,
	input  wire logic     s1Store,
	input  wire widthCode s1Width,
	input  wire byteAddr  s1Addr,
	input  wire dataWord  s1StoreData,
	input  wire regIdx    s1Rd,
	input  wire logic     s1Misaligned,
	input  wire logic     debugWe,
	input  wire byteAddr  debugAddr,
	input  wire dataWord  debugData,
	output logic          s2Valid,
	output logic          s2Store,
	output widthCode      s2Width,
	output logic [1:0]    s2Lane,
	output regIdx         s2Rd,
	output logic          s2Fault,
	output dataWord       s2ReadWord
);

	logic [memIndexBits-1:0] memIndex;    // Word index, wraps
	logic [memIndexBits-1:0] debugIndex;
	logic                    memWe;
	logic                    memRe;
	byteEnable               memBe;
	dataWord                 memWrData;
	dataWord                 memRdData;
	logic                    goodOp;      // Valid and aligned

	assign goodOp = s1Valid & ~s1Misaligned;

	//////////////////////////////////////////////////
	// Store lanes and byte enables
	//////////////////////////////////////////////////
	assign memWrData = s1StoreData << {s1Addr[1:0], 3'b000};  // Into its lane

	always_comb begin
		case (s1Width)
			opByte, opByteU:
				memBe = 4'b0001 << s1Addr[1:0];
			opHalf, opHalfU:
				memBe = 4'b0011 << s1Addr[1:0];  // Lane 0 or 2 only
			default:
				memBe = 4'b1111;
		endcase
	end

	assign memWe      = goodOp & s1Store;   // Faults never write
	assign memRe      = goodOp & ~s1Store;
	assign memIndex   = s1Addr[memIndexBits+1:2];
	assign debugIndex = debugAddr[memIndexBits+1:2];  // Bits 11:2

	dataMemory i_dataMemory (
		.clk        (clk),
		.memIndex   (memIndex),
		.memWe      (memWe),
		.memBe      (memBe),
		.memWrData  (memWrData),
		.memRe      (memRe),
		.debugWe    (debugWe),
		.debugIndex (debugIndex),
		.debugData  (debugData),
		.memRdData  (memRdData)
	);

	//////////////////////////////////////////////////
	// Stage 2 register, lines up with memRdData
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			s2Valid <= 1'b0;
		end else begin
			s2Valid <= s1Valid;
		end
	end

	always_ff @(posedge clk) begin
		s2Store <= s1Store;
		s2Width <= s1Width;
		s2Lane  <= s1Addr[1:0];
		s2Rd    <= s1Rd;
		s2Fault <= s1Misaligned;  // Qualified by s2Valid downstream
	end

	assign s2ReadWord = memRdData;  // Already registered in the RAM

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the load/store slice testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module memPipeTb -f files.f -o memPipeSim &&
./obj_dir/memPipeSim || exit 1
